// File: databuf_input_top.f
+incdir+rtl
rtl/databuf_pkg.sv
rtl/fifo_rd_if.sv
rtl/dc_fifo_input.sv
rtl/databuf_level_monitor.sv
rtl/databuf_drain.sv
rtl/databuf_input_top.sv
test/tb_databuf_input.sv

// File: Makefile
TOP := tb_databuf_input
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  make test   build with Verilator, run the testbench, check the log"
	@echo "  make clean  remove the build directory and the log"
	@echo "  make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f databuf_input_top.f -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: test/tb_databuf_input.sv
`timescale 1ns/1ps
`include "databuf_settings.svh"

module tb_databuf_input
    import databuf_pkg::*;
();

    localparam int CNT_W = $clog2(`DATABUF_HIGH_LIMIT_NUM);

    logic                           wr_clk;
    logic                           rd_clk;
    logic                           rst_n;
    sample_t                        wr_data;
    logic                           wr_en;
    logic                           full;
    logic                           high_water;
    logic [`DATABUF_DROP_WIDTH-1:0] drop_cnt;
    sample_t                        out_data;
    logic                           out_valid;
    logic                           out_ready;

    // scoreboard of accepted writes, oldest first
    sample_t                        exp_q[$];
    sample_t                        exp_head;
    sample_t                        held_data;
    int                             exp_cnt;
    int                             accepted;
    int                             cap_base;
    logic [`DATABUF_DROP_WIDTH-1:0] drop_model;
    logic                           hw_model;
    logic                           cap_phase;
    logic                           idle_check;
    logic                           writer_done;
    logic [CNT_W-1:0]               fifo_fill;
    int                             errors;
    int                             tests_run;
    int                             tests_failed;
    int                             err_mark;

    databuf_input_top databuf_input_top_inst (
        .wr_clk     (wr_clk),
        .rd_clk     (rd_clk),
        .rst_n      (rst_n),
        .wr_data    (wr_data),
        .wr_en      (wr_en),
        .full       (full),
        .high_water (high_water),
        .drop_cnt   (drop_cnt),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

    // write-side fill as the level monitor sees it
    assign fifo_fill = databuf_input_top_inst.wr_cnt;

    initial begin
        wr_clk = 1'b0;
        forever #20 wr_clk = ~wr_clk;
    end

    // the offset keeps every rd_clk edge away from every wr_clk edge
    initial begin
        rd_clk = 1'b0;
        #7;
        forever #28 rd_clk = ~rd_clk;
    end

    always @(posedge wr_clk) begin
        if (!rst_n) begin
            hw_model   = 1'b0;
            drop_model = '0;
        end else begin
            if (wr_en && !full) begin
                exp_q.push_back(wr_data);
                accepted++;
            end
            if (wr_en && full && drop_model != '1) begin
                drop_model = drop_model + 1'b1;
            end
            // sets at the high mark or on full, clears only at or below the low mark
            if (full || fifo_fill >= `DATABUF_HIGH_WATER) begin
                hw_model = 1'b1;
            end else if (fifo_fill <= `DATABUF_LOW_WATER) begin
                hw_model = 1'b0;
            end
            exp_head = (exp_q.size() > 0) ? exp_q[0] : '0;
            exp_cnt  = exp_q.size();
        end
    end

    always @(posedge rd_clk) begin
        if (rst_n && out_valid && out_ready && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
            exp_head = (exp_q.size() > 0) ? exp_q[0] : '0;
            exp_cnt  = exp_q.size();
        end
    end

    // out_data as it stood at the previous rd_clk edge
    always @(posedge rd_clk) begin
        held_data <= out_data;
    end

    a_reset_state: assert property (@(posedge wr_clk)
        $rose(rst_n) |-> (!out_valid && !full && !high_water && drop_cnt == '0)
    ) else begin
        errors++;
        $display("error %0t: after reset out_valid=%b full=%b high_water=%b drop_cnt=%0d, expected 0",
                 $time, $sampled(out_valid), $sampled(full), $sampled(high_water),
                 $sampled(drop_cnt));
    end

    a_no_extra: assert property (@(posedge rd_clk) disable iff (!rst_n)
        (out_valid && out_ready) |-> exp_cnt > 0
    ) else begin
        errors++;
        $display("output transfer at %0t with no accepted sample left to deliver", $time);
    end

    a_data_order: assert property (@(posedge rd_clk) disable iff (!rst_n)
        (out_valid && out_ready && exp_cnt > 0) |-> out_data == exp_head
    ) else begin
        errors++;
        $display("error %0t: out_data = %h, expected %h", $time, $sampled(out_data),
                 $sampled(exp_head));
    end

    a_hold: assert property (@(posedge rd_clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data))
    ) else begin
        errors++;
        $display("error %0t: out_valid = %b, out_data = %h, expected 1 and held value %h",
                 $time, $sampled(out_valid), $sampled(out_data), $sampled(held_data));
    end

    a_idle: assert property (@(posedge rd_clk) disable iff (!rst_n)
        idle_check |-> !out_valid
    ) else begin
        errors++;
        $display("error %0t: out_valid = 1, expected 0", $time);
    end

    a_capacity: assert property (@(posedge wr_clk) disable iff (!cap_phase)
        full |-> (accepted - cap_base == 17)
    ) else begin
        errors++;
        $display("error %0t: accepted writes = %0d, expected 17", $time,
                 $sampled(accepted) - $sampled(cap_base));
    end

    a_drop_count: assert property (@(posedge wr_clk) disable iff (!rst_n)
        drop_cnt == drop_model
    ) else begin
        errors++;
        $display("error %0t: drop_cnt = %0d, expected %0d", $time, $sampled(drop_cnt),
                 $sampled(drop_model));
    end

    a_high_water: assert property (@(posedge wr_clk) disable iff (!rst_n)
        high_water == hw_model
    ) else begin
        errors++;
        $display("error %0t: high_water = %b, expected %b", $time, $sampled(high_water),
                 $sampled(hw_model));
    end

    task automatic note_timeout(input string what);
        errors++;
        $display("timeout at %0t while waiting for %s", $time, what);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == err_mark) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    task automatic write_one();
        @(negedge wr_clk);
        wr_en   = 1'b1;
        wr_data = sample_t'($urandom);
        @(negedge wr_clk);
        wr_en   = 1'b0;
    endtask

    // keeps writing while stop_on_high selects the flag to wait for is still low
    task automatic fill_until(input logic stop_on_high);
        int n;
        n = 0;
        @(negedge wr_clk);
        while (!(stop_on_high ? high_water : full) && n < 40) begin
            wr_en   = 1'b1;
            wr_data = sample_t'($urandom);
            n++;
            @(negedge wr_clk);
        end
        wr_en = 1'b0;
        if (!(stop_on_high ? high_water : full)) begin
            note_timeout(stop_on_high ? "high_water to set" : "full to assert");
        end
    endtask

    task automatic wait_out_valid();
        int n;
        n = 0;
        while (!out_valid && n < 20) begin
            @(negedge rd_clk);
            n++;
        end
        if (!out_valid) note_timeout("out_valid to rise");
    endtask

    // slow_ready stops as soon as high_water clears, otherwise runs until empty
    task automatic drain(input logic slow_ready);
        int n;
        n = 0;
        while ((slow_ready ? high_water : (exp_cnt != 0 || out_valid)) && n < 400) begin
            @(negedge rd_clk);
            out_ready = slow_ready ? (($urandom % 4) == 0) : 1'b1;
            n++;
        end
        if (slow_ready ? high_water : (exp_cnt != 0 || out_valid)) begin
            note_timeout(slow_ready ? "high_water to clear" : "the buffer to drain");
        end
    endtask

    task automatic run_bursts(input int bursts);
        int len;
        int gap;
        int n;
        writer_done = 1'b0;
        fork
            begin
                for (int b = 0; b < bursts; b++) begin
                    len = 1 + int'($urandom % 8);
                    gap = int'($urandom % 6);
                    repeat (len) begin
                        @(negedge wr_clk);
                        wr_en   = 1'b1;
                        wr_data = sample_t'($urandom);
                    end
                    @(negedge wr_clk);
                    wr_en = 1'b0;
                    repeat (gap) @(negedge wr_clk);
                end
                writer_done = 1'b1;
            end
            begin
                n = 0;
                while ((!writer_done || exp_cnt != 0 || out_valid) && n < 2000) begin
                    @(negedge rd_clk);
                    out_ready = ($urandom % 4) != 0;
                    n++;
                end
                if (!writer_done || exp_cnt != 0 || out_valid) begin
                    note_timeout("random bursts to drain");
                end
            end
        join
    endtask

    initial begin
        void'($urandom(32'ha860_251a));
        rst_n        = 1'b0;
        wr_en        = 1'b0;
        wr_data      = '0;
        out_ready    = 1'b0;
        cap_phase    = 1'b0;
        idle_check   = 1'b0;
        writer_done  = 1'b0;
        exp_cnt      = 0;
        accepted     = 0;
        cap_base     = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        err_mark     = 0;
        repeat (4) @(posedge wr_clk);
        @(negedge wr_clk);
        rst_n = 1'b1;
        repeat (2) @(negedge wr_clk);
        finish_test("reset state");

        run_bursts(40);
        finish_test("data order");

        drain(1'b0);
        @(negedge rd_clk);
        out_ready = 1'b0;
        cap_base  = accepted;
        write_one();
        wait_out_valid();
        // a read frees its slot on the write side within three wr_clk edges
        repeat (3) @(negedge wr_clk);
        cap_phase = 1'b1;
        fill_until(1'b0);
        finish_test("capacity");

        repeat (5) write_one();
        cap_phase = 1'b0;
        finish_test("overflow counting");

        drain(1'b1);
        drain(1'b0);
        @(negedge rd_clk);
        out_ready = 1'b0;
        fill_until(1'b1);
        assert (!full) else begin
            errors++;
            $display("error %0t: full = 1, expected 0 when high_water rose", $time);
        end
        drain(1'b0);
        finish_test("high-water hysteresis");

        @(negedge rd_clk);
        out_ready = 1'b0;
        repeat (4) write_one();
        wait_out_valid();
        repeat (6) @(negedge rd_clk);
        drain(1'b0);
        idle_check = 1'b1;
        repeat (8) @(negedge rd_clk);
        idle_check = 1'b0;
        finish_test("back-pressure");

        $display("tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed,
                 errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: rtl/databuf_input_top.sv
`timescale 1ns/1ps
`include "databuf_settings.svh"

module databuf_input_top
    import databuf_pkg::*;
(
    input  logic                           wr_clk,
    input  logic                           rd_clk,
    input  logic                           rst_n,

    input  sample_t                        wr_data,
    input  logic                           wr_en,
    output logic                           full,
    output logic                           high_water,
    output logic [`DATABUF_DROP_WIDTH-1:0] drop_cnt,

    output sample_t                        out_data,
    output logic                           out_valid,
    input  logic                           out_ready
);

    logic [$clog2(`DATABUF_HIGH_LIMIT_NUM)-1:0] wr_cnt;

    fifo_rd_if rd_bus ();

    dc_fifo_input #(
        .DATA_BIT   (`DATABUF_DATA_WIDTH),
        .DATA_DEPTH ($clog2(`DATABUF_HIGH_LIMIT_NUM))
    ) dc_fifo_input_inst (
        .rst_n   (rst_n),
        .wr_clk  (wr_clk),
        .wr_data (wr_data),
        .wr_en   (wr_en),
        .wr_cnt  (wr_cnt),
        .full    (full),
        .rd_clk  (rd_clk),
        .rd      (rd_bus.fifo)
    );

    databuf_level_monitor databuf_level_monitor_inst (
        .wr_clk     (wr_clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .wr_cnt     (wr_cnt),
        .full       (full),
        .high_water (high_water),
        .drop_cnt   (drop_cnt)
    );

    databuf_drain databuf_drain_inst (
        .rd_clk    (rd_clk),
        .rst_n     (rst_n),
        .rd        (rd_bus.drain),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

// File: rtl/databuf_drain.sv
`timescale 1ns/1ps
`include "databuf_settings.svh"

module databuf_drain
    import databuf_pkg::*;
(
    input  logic     rd_clk,
    input  logic     rst_n,
    fifo_rd_if.drain rd,
    output sample_t  out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    logic reg_free;
    logic load;

    // the output register can take a word if it is empty or handing off now
    assign reg_free = !out_valid || out_ready;

    // rd_en stays low while the FIFO has nothing to give
    assign rd.rd_en = reg_free && !rd.empty;
    assign load     = rd.rd_en;

    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge rd_clk) begin
        if (load) begin
            out_data <= rd.rd_data;
        end
    end

    // a stalled word must not change under the consumer
    a_hold_when_stalled: assert property (
        @(posedge rd_clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    );

    // rd_cnt lags by one edge and at most one read happens in between,
    // so a count above one guarantees the FIFO still has a word now
    a_cnt_implies_data: assert property (
        @(posedge rd_clk) disable iff (!rst_n)
        rd.rd_cnt > 1 |-> !rd.empty
    );

endmodule

// File: rtl/databuf_level_monitor.sv
`timescale 1ns/1ps
`include "databuf_settings.svh"

module databuf_level_monitor
    import databuf_pkg::*;
(
    input  logic                                       wr_clk,
    input  logic                                       rst_n,
    input  logic                                       wr_en,
    input  logic [$clog2(`DATABUF_HIGH_LIMIT_NUM)-1:0] wr_cnt,
    input  logic                                       full,
    output logic                                       high_water,
    output logic [`DATABUF_DROP_WIDTH-1:0]             drop_cnt
);

    level_state_e state;
    level_state_e state_next;

    // wr_cnt reads zero when the FIFO is completely full, so full is checked too
    always_comb begin
        state_next = state;
        case (state)
            LEVEL_NORMAL: begin
                if (full || wr_cnt >= `DATABUF_HIGH_WATER) begin
                    state_next = LEVEL_HIGH;
                end
            end
            LEVEL_HIGH: begin
                if (!full && wr_cnt <= `DATABUF_LOW_WATER) begin
                    state_next = LEVEL_NORMAL;
                end
            end
            default: state_next = LEVEL_NORMAL;
        endcase
    end

    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= LEVEL_NORMAL;
        end else begin
            state <= state_next;
        end
    end

    assign high_water = (state == LEVEL_HIGH);

    // refused writes, held at all ones once saturated
    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            drop_cnt <= '0;
        end else if (wr_en && full && drop_cnt != '1) begin
            drop_cnt <= drop_cnt + 1'b1;
        end
    end

    a_drop_cnt_monotonic: assert property (
        @(posedge wr_clk) disable iff (!rst_n)
        drop_cnt >= $past(drop_cnt)
    );

endmodule

// File: rtl/dc_fifo_input.sv
`timescale 1ns/1ps
`include "databuf_settings.svh"

module dc_fifo_input #(
    parameter int DATA_BIT   = `DATABUF_DATA_WIDTH,
    parameter int DATA_DEPTH = $clog2(`DATABUF_HIGH_LIMIT_NUM)
) (
    input  logic                  rst_n,

    input  logic                  wr_clk,
    input  logic [DATA_BIT-1:0]   wr_data,
    input  logic                  wr_en,
    output logic [DATA_DEPTH-1:0] wr_cnt,
    output logic                  full,

    input  logic                  rd_clk,
    fifo_rd_if.fifo               rd
);

    // pointers carry one wrap bit above the address bits
    localparam int PTR_W = DATA_DEPTH + 1;

    logic [DATA_BIT-1:0]   mem [2**DATA_DEPTH];

    logic [PTR_W-1:0]      w_ptr;
    logic [PTR_W-1:0]      w_gray;
    logic [PTR_W-1:0]      w_gray_r;
    logic [PTR_W-1:0]      w_gray_rr;
    logic [PTR_W-1:0]      w_bin_sync;
    logic [DATA_DEPTH-1:0] wr_cnt_q;

    logic [PTR_W-1:0]      r_ptr;
    logic [PTR_W-1:0]      r_gray;
    logic [PTR_W-1:0]      r_gray_r;
    logic [PTR_W-1:0]      r_gray_rr;
    logic [PTR_W-1:0]      r_bin_sync;
    logic [DATA_DEPTH-1:0] rd_cnt_q;

    logic                  wr_fire;
    logic                  rd_fire;

    function automatic logic [PTR_W-1:0] gray2bin(input logic [PTR_W-1:0] gray);
        logic [PTR_W-1:0] bin;
        bin[PTR_W-1] = gray[PTR_W-1];
        for (int i = PTR_W - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

    assign wr_fire = wr_en && !full;
    assign rd_fire = rd.rd_en && !rd.empty;

    // write clock domain

    always_ff @(posedge wr_clk) begin
        if (wr_fire) begin
            mem[w_ptr[DATA_DEPTH-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            w_ptr <= '0;
        end else if (wr_fire) begin
            w_ptr <= w_ptr + 1'b1;
        end
    end

    assign w_gray = (w_ptr >> 1) ^ w_ptr;

    // read pointer crosses into the write domain as Gray code
    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            r_gray_r  <= '0;
            r_gray_rr <= '0;
        end else begin
            r_gray_r  <= r_gray;
            r_gray_rr <= r_gray_r;
        end
    end

    assign r_bin_sync = gray2bin(r_gray_rr);

    // the count wraps to zero when all entries are in use
    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_cnt_q <= '0;
        end else begin
            wr_cnt_q <= w_ptr[DATA_DEPTH-1:0] - r_bin_sync[DATA_DEPTH-1:0];
        end
    end

    assign wr_cnt = wr_cnt_q;

    // full when the write pointer is one lap ahead of the read pointer
    assign full = (w_gray[PTR_W-1:PTR_W-2] == ~r_gray_rr[PTR_W-1:PTR_W-2]) &&
                  (w_gray[PTR_W-3:0] == r_gray_rr[PTR_W-3:0]);

    // read clock domain

    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            r_ptr <= '0;
        end else if (rd_fire) begin
            r_ptr <= r_ptr + 1'b1;
        end
    end

    assign r_gray = (r_ptr >> 1) ^ r_ptr;

    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            w_gray_r  <= '0;
            w_gray_rr <= '0;
        end else begin
            w_gray_r  <= w_gray;
            w_gray_rr <= w_gray_r;
        end
    end

    assign w_bin_sync = gray2bin(w_gray_rr);

    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_cnt_q <= '0;
        end else begin
            rd_cnt_q <= w_bin_sync[DATA_DEPTH-1:0] - r_ptr[DATA_DEPTH-1:0];
        end
    end

    assign rd.rd_cnt  = rd_cnt_q;
    assign rd.rd_data = mem[r_ptr[DATA_DEPTH-1:0]];
    assign rd.empty   = (r_gray == w_gray_rr);

    // the write pointer never runs more than one lap ahead of the synchronized read pointer
    a_no_write_when_full: assert property (
        @(posedge wr_clk) disable iff (!rst_n)
        PTR_W'(w_ptr - r_bin_sync) <= 2**DATA_DEPTH
    );

    // the read pointer never passes the synchronized write pointer
    a_no_read_when_empty: assert property (
        @(posedge rd_clk) disable iff (!rst_n)
        PTR_W'(w_bin_sync - r_ptr) <= 2**DATA_DEPTH
    );

endmodule

// File: rtl/fifo_rd_if.sv
`timescale 1ns/1ps
`include "databuf_settings.svh"

// read port of the dual-clock FIFO, all signals in the rd_clk domain
interface fifo_rd_if
    import databuf_pkg::*;
();

    // head word, shown combinationally while empty is low
    sample_t                                     rd_data;
    logic    [$clog2(`DATABUF_HIGH_LIMIT_NUM)-1:0] rd_cnt;
    logic                                        empty;
    logic                                        rd_en;

    modport fifo (
        output rd_data,
        output rd_cnt,
        output empty,
        input  rd_en
    );

    modport drain (
        input  rd_data,
        input  rd_cnt,
        input  empty,
        output rd_en
    );

endinterface

// File: rtl/databuf_pkg.sv
`include "databuf_settings.svh"

package databuf_pkg;

    // one sample as it moves through the buffer
    typedef logic [`DATABUF_DATA_WIDTH-1:0] sample_t;

    // fill state seen by the write-side level monitor
    typedef enum logic {
        LEVEL_NORMAL = 1'b0,
        LEVEL_HIGH   = 1'b1
    } level_state_e;

endpackage

// File: rtl/databuf_settings.svh
`ifndef DATABUF_SETTINGS_SVH
`define DATABUF_SETTINGS_SVH

// width of one sample in bits
`define DATABUF_DATA_WIDTH 16

// buffer capacity in samples
// the FIFO address width is the base-2 log of this value
`define DATABUF_HIGH_LIMIT_NUM 16

// write-side fill levels for the high-water flag
// the flag sets at the high mark and clears at or below the low mark
`define DATABUF_HIGH_WATER 12
`define DATABUF_LOW_WATER 4

// width of the saturating counter of refused writes
`define DATABUF_DROP_WIDTH 8

`endif
